/* Bender.yml */
package:
  name: ooo_core

export_include_dirs:
  - common

sources:
  - files:
      - common/ooo_pkg.sv
      - verilog/decoder.sv
      - rename/rename_table.sv
      - rename/arch_regfile.sv
      - verilog/reorder_buffer.sv
      - verilog/alu.sv
      - verilog/multiplier.sv
      - verilog/ooo_core.sv
  - target: test
    files:
      - dv/tb_ooo_core.sv

/* common/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// data word width
`define OOO_XLEN 32

// architectural registers x0..x31
`define OOO_NUM_REGS 32

// reorder buffer entries, tag indexes them
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W 3

// one load cycle plus one cycle per multiplier bit
`define OOO_MUL_CYCLES 33

`endif

/* common/ooo_pkg.sv */
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0]  word_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [`OOO_TAG_W-1:0] rob_tag_t;

    // RV32 major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL  // goes to the multiplier, never the alu
    } alu_op_e;

endpackage

`default_nettype wire

/* dv/tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module tb_ooo_core;

    localparam int CLK_PERIOD  = 40;
    localparam int TOTAL_INSTR = 236;  // sum over all directed tests
    localparam int CYCLE_LIMIT = TOTAL_INSTR * (`OOO_MUL_CYCLES + 4) + 100;
    localparam int RAND_COUNT  = 200;

    // instruction kinds used by the stimulus and the reference model
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_MUL  = 6;
    localparam int K_ADDI = 7;
    localparam int K_ANDI = 8;
    localparam int K_ORI  = 9;
    localparam int K_XORI = 10;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_value;

    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    int          sent_count;
    int          commit_count;
    int          error_count;
    int          errors_at_start;
    int          sent_at_start;
    int          commits_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    int          seed;
    string       test_name;

    ooo_core i_ooo_core (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: %0d of %0d instructions committed after %0d cycles",
                     commit_count, sent_count, cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // commit monitor, compares against the program-order model queue
    always @(posedge clk) begin
        logic [4:0]  exp_rd;
        logic [31:0] exp_val;
        if (!reset && commit_valid === 1'b1) begin
            commit_count++;
            assert (exp_rd_q.size() != 0)
                else begin
                    $display("%s: commit of x%0d with no instruction outstanding",
                             test_name, commit_rd);
                    error_count++;
                end
            if (exp_rd_q.size() != 0) begin
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                assert (commit_rd === exp_rd && commit_value === exp_val)
                    else begin
                        $display("CHECK FAILED %s: expected x%0d = %h, actual x%0d = %h",
                                 test_name, exp_rd, exp_val, commit_rd, commit_value);
                        error_count++;
                    end
            end
        end
    end

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // runs the model, then sends one instruction once the window has room
    task automatic issue_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = model_regs[rs1];
        b = (kind >= K_ADDI) ? {{20{imm[11]}}, imm} : model_regs[rs2];
        word = '0;
        result = '0;
        case (kind)
            K_ADD:  word = r_format(7'h00, rs2, rs1, 3'b000, rd);
            K_SUB:  word = r_format(7'h20, rs2, rs1, 3'b000, rd);
            K_AND:  word = r_format(7'h00, rs2, rs1, 3'b111, rd);
            K_OR:   word = r_format(7'h00, rs2, rs1, 3'b110, rd);
            K_XOR:  word = r_format(7'h00, rs2, rs1, 3'b100, rd);
            K_SLT:  word = r_format(7'h00, rs2, rs1, 3'b010, rd);
            K_MUL:  word = r_format(7'h01, rs2, rs1, 3'b000, rd);
            K_ADDI: word = i_format(imm, rs1, 3'b000, rd);
            K_ANDI: word = i_format(imm, rs1, 3'b111, rd);
            K_ORI:  word = i_format(imm, rs1, 3'b110, rd);
            default: word = i_format(imm, rs1, 3'b100, rd);
        endcase
        case (kind)
            K_ADD, K_ADDI: result = a + b;
            K_SUB:         result = a - b;
            K_AND, K_ANDI: result = a & b;
            K_OR, K_ORI:   result = a | b;
            K_XOR, K_XORI: result = a ^ b;
            K_SLT:         result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       result = a * b;  // low word of the product
        endcase
        if (rd != 5'd0) begin
            model_regs[rd] = result;
        end
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(result);
        while (sent_count - commit_count >= `OOO_ROB_DEPTH) begin
            @(negedge clk);
        end
        instr_valid = 1'b1;
        instr       = word;
        sent_count++;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic reg_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        issue_instr(kind, rd, rs1, rs2, 12'h000);
    endtask

    task automatic imm_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        issue_instr(kind, rd, rs1, 5'd0, imm);
    endtask

    task automatic start_test(input string name);
        test_name        = name;
        errors_at_start  = error_count;
        sent_at_start    = sent_count;
        commits_at_start = commit_count;
    endtask

    task automatic finish_test();
        while (commit_count != sent_count) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);  // catch any stray commit
        assert (commit_count - commits_at_start == sent_count - sent_at_start)
            else begin
                $display("CHECK FAILED %s: expected %0d commits, actual %0d commits",
                         test_name, sent_count - sent_at_start,
                         commit_count - commits_at_start);
                error_count++;
            end
        tests_run++;
        if (error_count != errors_at_start) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", test_name, error_count - errors_at_start);
    endtask

    task automatic reset_idle_test();
        start_test("reset_idle");
        reset = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            assert (commit_valid === 1'b0)
                else begin
                    $display("CHECK FAILED %s: expected commit_valid 0 in reset, actual %b",
                             test_name, commit_valid);
                    error_count++;
                end
        end
        reset = 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (commit_valid === 1'b0)
                else begin
                    $display("CHECK FAILED %s: expected commit_valid 0 when idle, actual %b",
                             test_name, commit_valid);
                    error_count++;
                end
        end
        finish_test();
    endtask

    task automatic independent_alu_test();
        start_test("independent_alu");
        imm_op(K_ADDI, 5'd1, 5'd0, 12'd100);
        imm_op(K_ADDI, 5'd2, 5'd0, -12'sd25);
        reg_op(K_ADD, 5'd3, 5'd1, 5'd2);
        reg_op(K_SUB, 5'd4, 5'd1, 5'd2);
        reg_op(K_AND, 5'd5, 5'd1, 5'd2);
        reg_op(K_OR,  5'd6, 5'd1, 5'd2);
        reg_op(K_XOR, 5'd7, 5'd1, 5'd2);
        reg_op(K_SLT, 5'd8, 5'd2, 5'd1);
        reg_op(K_SLT, 5'd9, 5'd1, 5'd2);
        finish_test();
    endtask

    task automatic dependency_chain_test();
        start_test("dependency_chain");
        imm_op(K_ADDI, 5'd1, 5'd0, 12'd3);
        imm_op(K_ADDI, 5'd2, 5'd1, 12'd4);  // back-to-back dependent
        reg_op(K_ADD, 5'd3, 5'd2, 5'd1);
        reg_op(K_SUB, 5'd4, 5'd3, 5'd2);
        imm_op(K_XORI, 5'd5, 5'd4, 12'h055);
        imm_op(K_ORI, 5'd6, 5'd5, 12'h100);
        imm_op(K_ANDI, 5'd7, 5'd6, 12'h1f0);
        reg_op(K_SLT, 5'd8, 5'd7, 5'd6);
        reg_op(K_ADD, 5'd1, 5'd8, 5'd7);
        finish_test();
    endtask

    task automatic multiply_test();
        start_test("multiply");
        imm_op(K_ADDI, 5'd1, 5'd0, -12'sd7);
        imm_op(K_ADDI, 5'd2, 5'd0, 12'd13);
        reg_op(K_MUL, 5'd3, 5'd1, 5'd2);
        imm_op(K_ADDI, 5'd4, 5'd0, 12'd1);  // independent work behind the mul
        reg_op(K_ADD, 5'd5, 5'd2, 5'd2);
        reg_op(K_XOR, 5'd6, 5'd1, 5'd2);
        reg_op(K_OR, 5'd7, 5'd4, 5'd5);
        reg_op(K_ADD, 5'd8, 5'd3, 5'd1);    // needs the product
        imm_op(K_ADDI, 5'd9, 5'd0, -12'sd300);
        reg_op(K_MUL, 5'd10, 5'd9, 5'd1);
        reg_op(K_MUL, 5'd11, 5'd10, 5'd10);
        reg_op(K_ADD, 5'd12, 5'd11, 5'd3);
        finish_test();
    endtask

    task automatic same_rd_test();
        start_test("same_rd");
        imm_op(K_ADDI, 5'd10, 5'd0, 12'd5);
        imm_op(K_ADDI, 5'd10, 5'd0, 12'd9);
        reg_op(K_ADD, 5'd11, 5'd10, 5'd10);
        imm_op(K_ADDI, 5'd0, 5'd10, 12'd3);  // result dropped by x0
        reg_op(K_ADD, 5'd12, 5'd0, 5'd10);
        reg_op(K_ADD, 5'd13, 5'd0, 5'd0);
        finish_test();
    endtask

    task automatic random_mix_test();
        int kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [11:0] imm;
        start_test("random_mix");
        for (int n = 0; n < RAND_COUNT; n++) begin
            kind = $unsigned($random(seed)) % 11;
            rd   = $unsigned($random(seed)) % 6;  // x0..x5
            rs1  = $unsigned($random(seed)) % 6;
            rs2  = $unsigned($random(seed)) % 6;
            imm  = $random(seed);
            issue_instr(kind, rd, rs1, rs2, imm);
        end
        finish_test();
    endtask

    initial begin
        instr_valid  = 1'b0;
        instr        = '0;
        reset        = 1'b1;
        sent_count   = 0;
        commit_count = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_count  = 0;
        seed         = 32'h4ed0;
        test_name    = "none";
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        reset_idle_test();
        independent_alu_test();
        dependency_chain_test();
        multiply_test();
        same_rd_test();
        random_mix_test();

        $display("tests run %0d, failed %0d, errors %0d, instructions %0d, commits %0d",
                 tests_run, tests_failed, error_count, sent_count, commit_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rename/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module arch_regfile (
    input  logic              clk,
    input  logic              reset,
    input  ooo_pkg::reg_idx_t rs1, rs2,
    output ooo_pkg::word_t    rs1_value, rs2_value,
    input  logic              commit_valid,
    input  ooo_pkg::reg_idx_t commit_rd,
    input  ooo_pkg::word_t    commit_value
);
    import ooo_pkg::*;

    word_t regs [`OOO_NUM_REGS];

    // write-through so a dispatch sees the value committing this cycle
    assign rs1_value = (rs1 == '0) ? '0 :
                       (commit_valid && commit_rd == rs1) ? commit_value : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 :
                       (commit_valid && commit_rd == rs2) ? commit_value : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && commit_rd != '0) begin
            regs[commit_rd] <= commit_value;
        end
    end

endmodule

`default_nettype wire

/* rename/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module rename_table (
    input  logic              clk,
    input  logic              reset,
    input  ooo_pkg::reg_idx_t rs1, rs2,
    output logic              rs1_busy, rs2_busy,
    output ooo_pkg::rob_tag_t rs1_tag, rs2_tag,
    input  logic              alloc_valid,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  ooo_pkg::rob_tag_t alloc_tag,
    input  logic              commit_valid,
    input  ooo_pkg::reg_idx_t commit_rd,
    input  ooo_pkg::rob_tag_t commit_tag
);
    import ooo_pkg::*;

    logic [`OOO_NUM_REGS-1:0] busy;
    rob_tag_t                 tag [`OOO_NUM_REGS];
    logic                     alloc_we;
    logic                     commit_clr;

    assign alloc_we   = alloc_valid && (alloc_rd != '0);  // x0 never renamed
    assign commit_clr = commit_valid && busy[commit_rd] && (tag[commit_rd] == commit_tag);

    // a producer committing now is already visible in the regfile
    assign rs1_busy = busy[rs1] && !(commit_valid && tag[rs1] == commit_tag);
    assign rs2_busy = busy[rs2] && !(commit_valid && tag[rs2] == commit_tag);
    assign rs1_tag  = tag[rs1];
    assign rs2_tag  = tag[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (commit_clr) begin
                busy[commit_rd] <= 1'b0;
            end
            if (alloc_we) begin
                busy[alloc_rd] <= 1'b1;  // newer producer wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            tag[alloc_rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/ooo_pkg.sv
verilog/decoder.sv
rename/rename_table.sv
rename/arch_regfile.sv
verilog/reorder_buffer.sv
verilog/alu.sv
verilog/multiplier.sv
verilog/ooo_core.sv
dv/tb_ooo_core.sv

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic              clk,
    input  logic              reset,
    input  logic              alu_issue,
    input  ooo_pkg::alu_op_e  alu_op,
    input  ooo_pkg::word_t    alu_a, alu_b,
    input  ooo_pkg::rob_tag_t alu_issue_tag,
    output logic              alu_done,
    output ooo_pkg::rob_tag_t alu_tag,
    output ooo_pkg::word_t    alu_result
);
    import ooo_pkg::*;

    word_t result;

    always_comb begin
        case (alu_op)
            OP_ADD:  result = alu_a + alu_b;
            OP_SUB:  result = alu_a - alu_b;
            OP_AND:  result = alu_a & alu_b;
            OP_OR:   result = alu_a | alu_b;
            OP_XOR:  result = alu_a ^ alu_b;
            OP_SLT:  result = ($signed(alu_a) < $signed(alu_b)) ? word_t'(1) : '0;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_tag    <= alu_issue_tag;
            alu_result <= result;
        end
    end

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    output ooo_pkg::alu_op_e       op,
    output ooo_pkg::reg_idx_t      rd,
    output ooo_pkg::reg_idx_t      rs1,
    output ooo_pkg::reg_idx_t      rs2,
    output ooo_pkg::word_t         imm,
    output logic                   use_imm
);
    import ooo_pkg::*;

    opcode_e    opcode;
    logic [9:0] funct;
    logic       supported;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct  = {instr[31:25], instr[14:12]};  // funct7, funct3
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign imm    = {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        op        = OP_ADD;
        rs2       = instr[24:20];
        use_imm   = 1'b0;
        supported = 1'b1;
        case (opcode)
            OPC_OP: begin
                case (funct)
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_111: op = OP_AND;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_010: op = OP_SLT;
                    10'b0000001_000: op = OP_MUL;
                    default:         supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                rs2     = '0;  // no second source, never busy
                case (funct[2:0])
                    3'b000:  op = OP_ADD;
                    3'b111:  op = OP_AND;
                    3'b110:  op = OP_OR;
                    3'b100:  op = OP_XOR;
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    a_supported: assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> supported)
        else $error("unsupported instruction %h", instr);

endmodule

`default_nettype wire

/* verilog/multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module multiplier (
    input  logic              clk,
    input  logic              reset,
    input  logic              mul_issue,
    input  ooo_pkg::word_t    mul_a, mul_b,
    input  ooo_pkg::rob_tag_t mul_issue_tag,
    output logic              mul_busy,
    output logic              mul_done,
    output ooo_pkg::rob_tag_t mul_tag,
    output ooo_pkg::word_t    mul_result
);
    import ooo_pkg::*;

    localparam int STEPS = `OOO_MUL_CYCLES - 1;  // after the load cycle
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] step;
    word_t            mcand, mplier, acc;

    assign mul_busy   = (state != S_IDLE);
    assign mul_done   = (state == S_DONE);
    assign mul_result = acc;  // low word only

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (mul_issue) state <= S_RUN;
                S_RUN:   if (step == CNT_W'(STEPS - 1)) state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // shift-add, one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (state == S_IDLE && mul_issue) begin
            mcand   <= mul_a;
            mplier  <= mul_b;
            acc     <= '0;
            step    <= '0;
            mul_tag <= mul_issue_tag;
        end else if (state == S_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            step   <= step + 1'b1;
        end
    end

    a_issue_when_idle: assert property (@(posedge clk) disable iff (reset)
        mul_issue |-> !mul_busy)
        else $error("multiplier issued while busy");

    a_latency: assert property (@(posedge clk) disable iff (reset)
        mul_issue |-> ##(`OOO_MUL_CYCLES) mul_done)
        else $error("multiplier result not on time");

endmodule

`default_nettype wire

/* verilog/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value
);
    import ooo_pkg::*;

    // dispatch path
    alu_op_e  op;
    reg_idx_t rd, rs1, rs2;
    word_t    imm;
    logic     use_imm;
    logic     rs1_busy, rs2_busy;
    rob_tag_t rs1_tag, rs2_tag;
    word_t    rs1_value, rs2_value;
    rob_tag_t alloc_tag;

    // issue and result buses
    logic     alu_issue, mul_issue, mul_busy;
    alu_op_e  alu_op;
    word_t    alu_a, alu_b, mul_a, mul_b;
    rob_tag_t alu_issue_tag, mul_issue_tag;
    logic     alu_done, mul_done;
    rob_tag_t alu_tag, mul_tag;
    word_t    alu_result, mul_result;

    rob_tag_t commit_tag;

    decoder i_decoder (.*);

    rename_table i_rename_table (
        .alloc_valid (instr_valid),
        .alloc_rd    (rd),
        .*
    );

    arch_regfile i_arch_regfile (.*);

    reorder_buffer i_reorder_buffer (.*);

    alu i_alu (.*);

    multiplier i_multiplier (.*);

endmodule

`default_nettype wire

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_defs.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  ooo_pkg::alu_op_e  op,
    input  ooo_pkg::reg_idx_t rd,
    input  ooo_pkg::word_t    imm,
    input  logic              use_imm,
    input  logic              rs1_busy, rs2_busy,
    input  ooo_pkg::rob_tag_t rs1_tag, rs2_tag,
    input  ooo_pkg::word_t    rs1_value, rs2_value,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              alu_issue,
    output ooo_pkg::alu_op_e  alu_op,
    output ooo_pkg::word_t    alu_a, alu_b,
    output ooo_pkg::rob_tag_t alu_issue_tag,
    output logic              mul_issue,
    output ooo_pkg::word_t    mul_a, mul_b,
    output ooo_pkg::rob_tag_t mul_issue_tag,
    input  logic              mul_busy,
    input  logic              alu_done, mul_done,
    input  ooo_pkg::rob_tag_t alu_tag, mul_tag,
    input  ooo_pkg::word_t    alu_result, mul_result,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value,
    output ooo_pkg::rob_tag_t commit_tag
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;

    logic [DEPTH-1:0]    e_valid, e_issued, e_done;
    alu_op_e             e_op [DEPTH];
    reg_idx_t            e_rd [DEPTH];
    word_t               e_a [DEPTH], e_b [DEPTH], e_result [DEPTH];
    logic                e_a_rdy [DEPTH], e_b_rdy [DEPTH];
    rob_tag_t            e_a_tag [DEPTH], e_b_tag [DEPTH];
    rob_tag_t            head, tail, alu_sel, mul_sel;
    logic [`OOO_TAG_W:0] count;
    logic                src_a_rdy, src_b_rdy;
    word_t               src_a, src_b;

    function automatic logic bus_hit(input rob_tag_t tag);
        return (alu_done && alu_tag == tag) || (mul_done && mul_tag == tag);
    endfunction

    function automatic word_t bus_value(input rob_tag_t tag);
        return (alu_done && alu_tag == tag) ? alu_result : mul_result;
    endfunction

    // busy source: stored result, else same-cycle bus, else wait
    always_comb begin
        src_a_rdy = !rs1_busy || e_done[rs1_tag] || bus_hit(rs1_tag);
        src_a     = !rs1_busy ? rs1_value :
                    e_done[rs1_tag] ? e_result[rs1_tag] : bus_value(rs1_tag);
        src_b_rdy = use_imm || !rs2_busy || e_done[rs2_tag] || bus_hit(rs2_tag);
        src_b     = use_imm ? imm : !rs2_busy ? rs2_value :
                    e_done[rs2_tag] ? e_result[rs2_tag] : bus_value(rs2_tag);
    end

    // scan youngest to oldest so the oldest candidate is kept
    always_comb begin
        rob_tag_t idx;
        logic     mul_cand;
        alu_issue = 1'b0;
        mul_cand  = 1'b0;
        alu_sel   = head;
        mul_sel   = head;
        for (int k = DEPTH - 1; k >= 0; k--) begin
            idx = head + rob_tag_t'(k);
            if (e_valid[idx] && !e_issued[idx] && e_a_rdy[idx] && e_b_rdy[idx]) begin
                if (e_op[idx] == OP_MUL) begin
                    mul_cand = 1'b1;
                    mul_sel  = idx;
                end else begin
                    alu_issue = 1'b1;
                    alu_sel   = idx;
                end
            end
        end
        mul_issue = mul_cand && !mul_busy;
    end

    assign alu_op        = e_op[alu_sel];
    assign alu_a         = e_a[alu_sel];
    assign alu_b         = e_b[alu_sel];
    assign alu_issue_tag = alu_sel;
    assign mul_a         = e_a[mul_sel];
    assign mul_b         = e_b[mul_sel];
    assign mul_issue_tag = mul_sel;

    assign alloc_tag    = tail;
    assign commit_valid = e_valid[head] && e_done[head];
    assign commit_rd    = e_rd[head];
    assign commit_value = e_result[head];
    assign commit_tag   = head;

    always_ff @(posedge clk) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            e_valid  <= '0;
            e_issued <= '0;
            e_done   <= '0;
        end else begin
            if (commit_valid) begin
                e_valid[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            if (alu_issue) e_issued[alu_sel] <= 1'b1;
            if (mul_issue) e_issued[mul_sel] <= 1'b1;
            if (alu_done) e_done[alu_tag] <= 1'b1;
            if (mul_done) e_done[mul_tag] <= 1'b1;
            if (instr_valid) begin
                e_valid[tail]  <= 1'b1;
                e_issued[tail] <= 1'b0;
                e_done[tail]   <= 1'b0;
                tail           <= tail + 1'b1;
            end
            case ({instr_valid, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // wakeup, results and the new entry; dispatch comes last and wins
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (!e_a_rdy[i] && bus_hit(e_a_tag[i])) begin
                e_a_rdy[i] <= 1'b1;
                e_a[i]     <= bus_value(e_a_tag[i]);
            end
            if (!e_b_rdy[i] && bus_hit(e_b_tag[i])) begin
                e_b_rdy[i] <= 1'b1;
                e_b[i]     <= bus_value(e_b_tag[i]);
            end
        end
        if (alu_done) e_result[alu_tag] <= alu_result;
        if (mul_done) e_result[mul_tag] <= mul_result;
        if (instr_valid) begin
            e_op[tail]    <= op;
            e_rd[tail]    <= rd;
            e_a[tail]     <= src_a;
            e_a_rdy[tail] <= src_a_rdy;
            e_a_tag[tail] <= rs1_tag;
            e_b[tail]     <= src_b;
            e_b_rdy[tail] <= src_b_rdy;
            e_b_tag[tail] <= rs2_tag;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> count < DEPTH)
        else $error("dispatch into a full reorder buffer");

    a_one_result_per_tag: assert property (@(posedge clk) disable iff (reset)
        !(alu_done && mul_done && alu_tag == mul_tag))
        else $error("alu and multiplier both returned tag %0d", alu_tag);

endmodule

`default_nettype wire
